// ==== program.hex ====
// One 16-bit instruction word per line in hex, starting at address 0
// Fields: opcode[15:12] rd or cond[11:8] rs[7:4] rt or imm[3:0]
a105 // LLB r1, 0x05
a207 // LLB r2, 0x07
0312 // ADD r3, r1, r2
b312 // LHB r3, 0x12
9302 // SW r3, 4(r0)
8402 // LW r4, 4(r0)
3541 // XOR r5, r4, r1
ca01 // B LE, not taken
c401 // B GT, taken
a911 // squashed marker
4654 // SLL r6, r5, 4
5763 // SRL r7, r6, 3
2873 // AND r8, r7, r3
c001 // B NE, not taken
c201 // B EQ, taken
a922 // squashed marker
c601 // B LT, not taken
cc01 // B OV, not taken
c801 // B GE, taken
aa33 // squashed marker
1b12 // SUB r11, r1, r2
c001 // B NE, taken
aa44 // squashed marker
c201 // B EQ, not taken
c801 // B GE, not taken
c601 // B LT, taken
ac55 // squashed marker
adff // LLB r13, 0xff
bd7f // LHB r13, 0x7f
0edd // ADD r14, r13, r13
cc01 // B OV, taken
af66 // squashed marker
ca01 // B LE, taken
af77 // squashed marker
ec00 // PCS r12
af4c // LLB r15, 0x4c
d0f0 // BR r15
a988 // squashed marker
ce01 // B AL, taken
aa99 // squashed marker
0012 // ADD r0, r1, r2
090b // ADD r9, r0, r11
f000 // HLT
aabb // never fetched into decode

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f verilog.f --top-module cpuTb

./obj_dir/VcpuTb +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1

// ==== tb/cpuTb.sv ====
module cpuTb;
	import cpuPkg::*;

	localparam int retireTimeout = 20;
	localparam int haltTimeout = 30;
	localparam int holdCycles = 8;
	localparam int modelStepLimit = 1000;

	logic clk = 1'b0;
	logic reset;
	logic [dataWidth-1:0] pc;
	wbBusT retire;
	logic hlt;

	// Reference ISA state
	wordT prog [imemDepth];
	wordT modelRegs [regCount];
	wordT modelMem [dmemDepth];
	wbBusT expected [$];
	// Address of HLT in the model
	wordT modelHaltPc;

	int errors;
	int checks;
	int testsRun;
	int testsFailed;

	cpu uut (.clk(clk), .reset(reset), .pc(pc), .retire(retire), .hlt(hlt));

	always #20 clk = ~clk;

	// Branch condition against current flags
	function automatic logic condHolds(input condT c, input flagsT f);
		case (c)
			condNe: return !f.z;
			condEq: return f.z;
			condGt: return !f.z && !f.n;
			condLt: return f.n;
			condGe: return f.z || !f.n;
			condLe: return f.n || f.z;
			condOv: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	// Register write in the model where r0 stays zero and never retires
	task automatic modelWrite(input regIdxT rd, input wordT val);
		wbBusT ev;
		if (rd != '0) begin
			modelRegs[rd] = val;
			ev.en = 1'b1;
			ev.regAddr = rd;
			ev.data = val;
			expected.push_back(ev);
		end
	endtask

	// Plain in-order execution of the loaded program up to HLT
	task automatic runModel();
		wordT pcM;
		wordT nextPc;
		wordT instr;
		wordT a;
		wordT b;
		wordT res;
		wordT addr;
		regIdxT rd;
		flagsT fl;
		int sx;
		int steps;
		logic done;
		logic arith;
		logic zOnly;
		pcM = '0;
		fl = '0;
		done = 1'b0;
		steps = 0;
		sx = 0;
		modelHaltPc = '0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < dmemDepth; i++) begin
			modelMem[i] = '0;
		end
		while (!done && steps < modelStepLimit) begin
			instr = prog[pcM[$clog2(imemDepth):1]];
			rd = instr[11:8];
			a = modelRegs[instr[7:4]];
			b = modelRegs[instr[3:0]];
			nextPc = pcM + 16'd2;
			// rs plus imm4 scaled to words
			addr = a + {{11{instr[3]}}, instr[3:0], 1'b0};
			arith = 1'b0;
			zOnly = 1'b0;
			res = '0;
			case (opcodeT'(instr[15:12]))
				opAdd: begin
					res = a + b;
					sx = int'($signed(a)) + int'($signed(b));
					arith = 1'b1;
				end
				opSub: begin
					res = a - b;
					sx = int'($signed(a)) - int'($signed(b));
					arith = 1'b1;
				end
				opAnd: begin
					res = a & b;
					zOnly = 1'b1;
				end
				opXor: begin
					res = a ^ b;
					zOnly = 1'b1;
				end
				opSll: begin
					res = a << instr[3:0];
					zOnly = 1'b1;
				end
				opSrl: begin
					res = a >> instr[3:0];
					zOnly = 1'b1;
				end
				opLw: modelWrite(rd, modelMem[addr[$clog2(dmemDepth):1]]);
				opSw: modelMem[addr[$clog2(dmemDepth):1]] = modelRegs[rd];
				opLlb: modelWrite(rd, {8'h00, instr[7:0]});
				opLhb: modelWrite(rd, {instr[7:0], modelRegs[rd][7:0]});
				opB: begin
					if (condHolds(condT'(instr[11:9]), fl)) begin
						nextPc = nextPc + {{6{instr[8]}}, instr[8:0], 1'b0};
					end
				end
				opBr: nextPc = a;
				opPcs: modelWrite(rd, nextPc);
				opHlt: begin
					done = 1'b1;
					modelHaltPc = pcM;
				end
				default: ;
			endcase
			if (arith) begin
				fl.n = res[dataWidth-1];
				// Signed result out of 16-bit range
				fl.v = (sx > 32767) || (sx < -32768);
			end
			if (arith || zOnly) begin
				fl.z = (res == '0);
				modelWrite(rd, res);
			end
			pcM = nextPc;
			steps++;
		end
		if (!done) begin
			$display("model did not reach HLT within %0d steps", modelStepLimit);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int bad);
		testsRun++;
		if (bad != 0) begin
			testsFailed++;
		end
		$display("test %s: %s (%0d errors)", name, (bad == 0) ? "ok" : "bad", bad);
		errors += bad;
	endtask

	// Each DUT retire event against the model in order
	task automatic checkRetireStream();
		int idx;
		int waited;
		int bad;
		logic timedOut;
		bad = 0;
		timedOut = 1'b0;
		for (idx = 0; idx < expected.size() && !timedOut; idx++) begin
			@(negedge clk);
			waited = 1;
			while (!retire.en && waited < retireTimeout) begin
				@(negedge clk);
				waited++;
			end
			if (!retire.en) begin
				$display("timeout: retire event %0d of %0d never arrived", idx, expected.size());
				timedOut = 1'b1;
				bad++;
			end else begin
				checks++;
				assert (retire.regAddr == expected[idx].regAddr) else begin
					$display("FAIL retire.regAddr event %0d: expected 0x%h got 0x%h",
						idx, expected[idx].regAddr, retire.regAddr);
					bad++;
				end
				assert (retire.data == expected[idx].data) else begin
					$display("FAIL retire.data event %0d: expected 0x%h got 0x%h",
						idx, expected[idx].data, retire.data);
					bad++;
				end
			end
		end
		reportTest("retire stream", bad);
	endtask

	// Wait for hlt with no extra retires and check that pc and hlt hold
	task automatic checkHalt();
		int waited;
		int bad;
		wordT pcAtHalt;
		bad = 0;
		waited = 0;
		while (!hlt && waited < haltTimeout) begin
			@(negedge clk);
			waited++;
			assert (!retire.en) else begin
				$display("FAIL retire.en: expected 0x0 got 0x1 (r%0d, data 0x%h)",
					retire.regAddr, retire.data);
				bad++;
			end
		end
		if (!hlt) begin
			$display("timeout: hlt did not rise within %0d cycles", haltTimeout);
			bad++;
		end else begin
			// Fetch freezes one word past HLT
			pcAtHalt = modelHaltPc + 16'd2;
			for (int i = 0; i < holdCycles; i++) begin
				@(negedge clk);
				checks++;
				assert (hlt) else begin
					$display("FAIL hlt: expected 0x1 got 0x%h", hlt);
					bad++;
				end
				assert (pc == pcAtHalt) else begin
					$display("FAIL pc: expected 0x%h got 0x%h", pcAtHalt, pc);
					bad++;
				end
			end
		end
		reportTest("halt", bad);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		testsRun = 0;
		testsFailed = 0;
		reset = 1'b1;
		for (int i = 0; i < imemDepth; i++) begin
			prog[i] = '0;
		end
		$readmemh("program.hex", prog);
		runModel();
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		checkRetireStream();
		checkHalt();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			testsRun, testsFailed, checks, errors, uut.props.failCount);
		if (errors == 0 && uut.props.failCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== tb/cpu_props.sv ====
module cpu_props (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::dataWidth-1:0] pc,
	input cpuPkg::wbBusT retire,
	input logic hlt
);

	// Failure tally, read from the testbench top at end of run
	int failCount = 0;

	// Reset state, held through the first cycle after release
	resetClears: assert property (@(posedge clk)
		reset |=> (pc == '0 && !hlt && !retire.en))
	else begin
		failCount++;
		$error("pc, hlt or retire.en not cleared by reset: pc 0x%h", pc);
	end

	// A retire event carries a known register and value
	retireKnown: assert property (@(posedge clk) disable iff (reset)
		retire.en |-> !$isunknown({retire.regAddr, retire.data}))
	else begin
		failCount++;
		$error("retire bus has unknown bits while en is set");
	end

	// r0 is never a retire target, so never reported nonzero
	noR0Retire: assert property (@(posedge clk) disable iff (reset)
		retire.en |-> retire.regAddr != '0)
	else begin
		failCount++;
		$error("retire to r0 with data 0x%h", retire.data);
	end

	// Nothing retires once HLT has left the pipe
	quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !retire.en)
	else begin
		failCount++;
		$error("retire to r%0d while hlt is high", retire.regAddr);
	end

	// hlt is sticky until reset
	haltSticky: assert property (@(posedge clk) disable iff (reset)
		hlt |=> hlt)
	else begin
		failCount++;
		$error("hlt dropped without reset");
	end

	// Fetch frozen after halt
	pcFrozen: assert property (@(posedge clk) disable iff (reset)
		hlt |=> $stable(pc))
	else begin
		failCount++;
		$error("pc moved to 0x%h after hlt", pc);
	end

	// Redirects and stalls keep pc on a halfword boundary
	pcAligned: assert property (@(posedge clk) disable iff (reset)
		pc[0] == 1'b0)
	else begin
		failCount++;
		$error("odd pc 0x%h", pc);
	end

endmodule

bind cpu cpu_props props (
	.clk(clk), .reset(reset), .pc(pc), .retire(retire), .hlt(hlt)
);

// ==== verilog.f ====
verilog/cpuPkg.sv
verilog/pipelineReg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpu.sv
tb/cpu_props.sv
tb/cpuTb.sv

// ==== verilog/cpu.sv ====
module cpu (
	input logic clk,
	input logic reset,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output cpuPkg::wbBusT retire,
	output logic hlt
);
	import cpuPkg::*;

	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;
	memWbT memWbD;
	memWbT memWbQ;
	flagsT exFlags;
	ctrlT exCtrl;
	wordT branchTarget;
	logic branchTaken;
	logic stall;
	logic halted;
	logic hltSticky;

	fetchStage ifStage (
		.clk(clk), .reset(reset), .stall(stall), .halted(halted),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.pc(pc), .ifId(ifIdD)
	);

	// Held on stall or halt, squashed by a taken branch
	pipelineReg #(.payloadT(ifIdT)) ifIdReg (
		.clk(clk), .reset(reset), .enable(!(stall || halted)),
		.flush(branchTaken), .d(ifIdD), .q(ifIdQ)
	);

	decodeStage idStage (
		.clk(clk), .reset(reset), .ifId(ifIdQ), .exFlags(exFlags),
		.exSetsFlags(exCtrl), .exRd(idExQ.rd), .exMemRead(idExQ.ctrl.memRead),
		.wb(retire), .idEx(idExD), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .stall(stall), .halted(halted)
	);

	// Load-use bubble enters here
	pipelineReg #(.payloadT(idExT)) idExReg (
		.clk(clk), .reset(reset), .enable(1'b1),
		.flush(stall), .d(idExD), .q(idExQ)
	);

	executeStage exStage (
		.clk(clk), .reset(reset), .idEx(idExQ), .exMemFwd(exMemQ),
		.wb(retire), .exMem(exMemD), .flags(exFlags), .setsFlags(exCtrl)
	);

	pipelineReg #(.payloadT(exMemT)) exMemReg (
		.clk(clk), .reset(reset), .enable(1'b1),
		.flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	memoryStage memStage (
		.clk(clk), .reset(reset), .exMem(exMemQ), .memWb(memWbD)
	);

	pipelineReg #(.payloadT(memWbT)) memWbReg (
		.clk(clk), .reset(reset), .enable(1'b1),
		.flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	// Writeback is the memWb register itself
	assign retire.en = memWbQ.regWrite;
	assign retire.regAddr = memWbQ.rd;
	assign retire.data = memWbQ.wbData;

	// Halt stays up once HLT retires
	always_ff @(posedge clk) begin
		if (reset) begin
			hltSticky <= 1'b0;
		end else if (memWbQ.isHalt) begin
			hltSticky <= 1'b1;
		end
	end

	assign hlt = memWbQ.isHalt || hltSticky;

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	// Datapath and storage sizes
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdxWidth = $clog2(regCount);
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regIdxWidth-1:0] regIdxT;

	// Opcode field, bits 15:12 (6 and 7 unused)
	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opAnd = 4'h2,
		opXor = 4'h3,
		opSll = 4'h4,
		opSrl = 4'h5,
		opLw = 4'h8,
		opSw = 4'h9,
		opLlb = 4'ha,
		opLhb = 4'hb,
		opB = 4'hc,
		opBr = 4'hd,
		opPcs = 4'he,
		opHlt = 4'hf
	} opcodeT;

	// Branch condition, bits 11:9 of B
	typedef enum logic [2:0] {
		condNe = 3'b000,
		condEq = 3'b001,
		condGt = 3'b010,
		condLt = 3'b011,
		condGe = 3'b100,
		condLe = 3'b101,
		condOv = 3'b110,
		condAl = 3'b111
	} condT;

	// Writeback source
	typedef enum logic [1:0] {
		srcAlu = 2'd0,
		srcMem = 2'd1,
		srcImm = 2'd2,
		srcPcs = 2'd3
	} srcSelT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluImm;
		logic setsAll;
		logic setsZ;
		srcSelT wbSrc;
		logic isHalt;
	} ctrlT;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flagsT;

	// Stage payloads, all zero is a bubble
	typedef struct packed {
		wordT instr;
		wordT pcPlus2;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		opcodeT opcode;
		regIdxT rd;
		regIdxT rs;
		regIdxT rt;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		wordT pcPlus2;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		regIdxT rd;
		wordT aluResult;
		wordT storeData;
		wordT imm;
		wordT pcPlus2;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		regIdxT rd;
		wordT wbData;
		logic isHalt;
	} memWbT;

	// Retire bus out of the memWb register
	typedef struct packed {
		logic en;
		regIdxT regAddr;
		wordT data;
	} wbBusT;

endpackage

// ==== verilog/decodeStage.sv ====
module decodeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::ifIdT ifId,
	input cpuPkg::flagsT exFlags,
	input cpuPkg::ctrlT exSetsFlags,
	input cpuPkg::regIdxT exRd,
	input logic exMemRead,
	input cpuPkg::wbBusT wb,
	output cpuPkg::idExT idEx,
	output logic branchTaken,
	output logic [cpuPkg::dataWidth-1:0] branchTarget,
	output logic stall,
	output logic halted
);
	import cpuPkg::*;

	wordT regs [regCount];
	opcodeT op;
	condT cond;
	regIdxT rdF;
	regIdxT rsF;
	regIdxT secF;
	ctrlT ctrl;
	wordT imm;
	wordT rsVal;
	wordT secVal;
	regIdxT memRdQ;
	logic memWrQ;
	logic haltedQ;
	logic valid;
	logic usesRs;
	logic usesSec;
	logic isB;
	logic isBr;
	logic condTrue;
	logic loadUse;
	logic brHazard;

	// r0 reads zero and a same-cycle retire write passes through
	function automatic wordT readReg(input regIdxT addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb.en && wb.regAddr == addr) begin
			return wb.data;
		end
		return regs[addr];
	endfunction

	// Bubbles carry pcPlus2 of zero
	assign valid = (ifId.pcPlus2 != '0) && !haltedQ;
	assign op = opcodeT'(ifId.instr[15:12]);
	assign cond = condT'(ifId.instr[11:9]);
	assign rdF = ifId.instr[11:8];
	assign rsF = ifId.instr[7:4];

	// SW and LHB read rd as second operand
	assign secF = (op == opSw || op == opLhb) ? rdF : ifId.instr[3:0];

	always_comb begin
		ctrl = '0;
		usesRs = 1'b0;
		usesSec = 1'b0;
		isB = 1'b0;
		isBr = 1'b0;
		imm = '0;
		case (op)
			opAdd, opSub: begin
				ctrl.regWrite = 1'b1;
				ctrl.setsAll = 1'b1;
				usesRs = 1'b1;
				usesSec = 1'b1;
			end
			opAnd, opXor: begin
				ctrl.regWrite = 1'b1;
				ctrl.setsZ = 1'b1;
				usesRs = 1'b1;
				usesSec = 1'b1;
			end
			opSll, opSrl: begin
				ctrl.regWrite = 1'b1;
				ctrl.setsZ = 1'b1;
				ctrl.aluImm = 1'b1;
				usesRs = 1'b1;
				imm = {12'h000, ifId.instr[3:0]};
			end
			opLw, opSw: begin
				ctrl.regWrite = (op == opLw);
				ctrl.memRead = (op == opLw);
				ctrl.memWrite = (op == opSw);
				ctrl.aluImm = 1'b1;
				ctrl.wbSrc = srcMem;
				usesRs = 1'b1;
				usesSec = (op == opSw);
				// Word offset, sign extended
				imm = {{11{ifId.instr[3]}}, ifId.instr[3:0], 1'b0};
			end
			opLlb, opLhb: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = (op == opLlb) ? srcImm : srcAlu;
				usesSec = (op == opLhb);
				imm = {8'h00, ifId.instr[7:0]};
			end
			opB: isB = 1'b1;
			opBr: begin
				isBr = 1'b1;
				usesRs = 1'b1;
			end
			opPcs: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = srcPcs;
			end
			opHlt: ctrl.isHalt = 1'b1;
			default: ;
		endcase
		// Never write r0
		if (rdF == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

	always_comb begin
		rsVal = readReg(rsF);
		secVal = readReg(secF);
	end

	// exFlags already merges the EX result when it sets flags
	always_comb begin
		case (cond)
			condNe: condTrue = !exFlags.z;
			condEq: condTrue = exFlags.z;
			condGt: condTrue = !exFlags.z && !exFlags.n;
			condLt: condTrue = exFlags.n;
			condGe: condTrue = exFlags.z || !exFlags.n;
			condLe: condTrue = exFlags.n || exFlags.z;
			condOv: condTrue = exFlags.v;
			default: condTrue = 1'b1;
		endcase
	end

	// Load in EX feeding this instruction
	assign loadUse = exMemRead && exSetsFlags.regWrite &&
		((usesRs && exRd == rsF) || (usesSec && exRd == secF));

	// BR waits until its target register reaches the retire bus
	assign brHazard = isBr && ((exSetsFlags.regWrite && exRd == rsF) ||
		(memWrQ && memRdQ == rsF));

	assign stall = valid && (loadUse || brHazard);
	assign branchTaken = valid && !stall && ((isB && condTrue) || isBr);
	assign branchTarget = isBr ? rsVal :
		ifId.pcPlus2 + {{6{ifId.instr[8]}}, ifId.instr[8:0], 1'b0};
	assign halted = haltedQ || (valid && ctrl.isHalt);

	// Shadow of the MEM destination plus halt latch
	always_ff @(posedge clk) begin
		if (reset) begin
			haltedQ <= 1'b0;
			memWrQ <= 1'b0;
			memRdQ <= '0;
		end else begin
			memWrQ <= exSetsFlags.regWrite;
			memRdQ <= exRd;
			if (valid && ctrl.isHalt) begin
				haltedQ <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb.en) begin
			regs[wb.regAddr] <= wb.data;
		end
	end

	always_comb begin
		idEx = '0;
		if (valid) begin
			idEx.ctrl = ctrl;
			idEx.opcode = op;
			idEx.rd = rdF;
			idEx.rs = rsF;
			idEx.rt = secF;
			idEx.rsVal = rsVal;
			idEx.rtVal = secVal;
			idEx.imm = imm;
			idEx.pcPlus2 = ifId.pcPlus2;
		end
	end

endmodule

// ==== verilog/executeStage.sv ====
module executeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::idExT idEx,
	input cpuPkg::exMemT exMemFwd,
	input cpuPkg::wbBusT wb,
	output cpuPkg::exMemT exMem,
	output cpuPkg::flagsT flags,
	output cpuPkg::ctrlT setsFlags
);
	import cpuPkg::*;

	flagsT flagsQ;
	wordT memFwdVal;
	wordT opA;
	wordT opRt;
	wordT opB;
	wordT sum;
	wordT diff;
	wordT result;
	logic ovf;

	// Youngest producer wins
	function automatic wordT forwardOp(input regIdxT src, input wordT regVal);
		if (exMemFwd.ctrl.regWrite && exMemFwd.rd == src) begin
			return memFwdVal;
		end
		if (wb.en && wb.regAddr == src) begin
			return wb.data;
		end
		return regVal;
	endfunction

	// Value the MEM instruction will write
	// Loads never reach here because of the load-use stall
	always_comb begin
		case (exMemFwd.ctrl.wbSrc)
			srcImm: memFwdVal = exMemFwd.imm;
			srcPcs: memFwdVal = exMemFwd.pcPlus2;
			default: memFwdVal = exMemFwd.aluResult;
		endcase
	end

	always_comb begin
		opA = forwardOp(idEx.rs, idEx.rsVal);
		opRt = forwardOp(idEx.rt, idEx.rtVal);
		opB = idEx.ctrl.aluImm ? idEx.imm : opRt;
		sum = opA + opB;
		diff = opA - opB;
		ovf = 1'b0;
		case (idEx.opcode)
			opAdd: begin
				result = sum;
				ovf = (opA[dataWidth-1] == opB[dataWidth-1]) &&
					(sum[dataWidth-1] != opA[dataWidth-1]);
			end
			opSub: begin
				result = diff;
				ovf = (opA[dataWidth-1] != opB[dataWidth-1]) &&
					(diff[dataWidth-1] != opA[dataWidth-1]);
			end
			opAnd: result = opA & opB;
			opXor: result = opA ^ opB;
			opSll: result = opA << opB[3:0];
			opSrl: result = opA >> opB[3:0];
			// New high byte over the old low byte
			opLhb: result = {idEx.imm[7:0], opRt[7:0]};
			// Load and store address
			default: result = sum;
		endcase
	end

	// Next flag state, also what decode sees this cycle
	always_comb begin
		flags = flagsQ;
		if (idEx.ctrl.setsAll) begin
			flags.n = result[dataWidth-1];
			flags.v = ovf;
		end
		if (idEx.ctrl.setsAll || idEx.ctrl.setsZ) begin
			flags.z = (result == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flagsQ <= '0;
		end else if (idEx.ctrl.setsAll || idEx.ctrl.setsZ) begin
			flagsQ <= flags;
		end
	end

	assign setsFlags = idEx.ctrl;

	always_comb begin
		exMem.ctrl = idEx.ctrl;
		exMem.rd = idEx.rd;
		exMem.aluResult = result;
		exMem.storeData = opRt;
		exMem.imm = idEx.imm;
		exMem.pcPlus2 = idEx.pcPlus2;
	end

endmodule

// ==== verilog/fetchStage.sv ====
module fetchStage (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic halted,
	input logic branchTaken,
	input logic [cpuPkg::dataWidth-1:0] branchTarget,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output cpuPkg::ifIdT ifId
);
	import cpuPkg::*;

	// Instruction ROM, one word per entry
	wordT rom [imemDepth];
	wordT pcPlus2;

	initial begin
		$readmemh("program.hex", rom);
	end

	// Sequential successor
	assign pcPlus2 = pc + wordT'(2);

	// Redirect first, then hold on stall or halt
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else if (!(stall || halted)) begin
			pc <= pcPlus2;
		end
	end

	// Byte address to word index
	assign ifId.instr = rom[pc[$clog2(imemDepth):1]];

	// Nonzero pcPlus2 marks a real instruction in ifId
	assign ifId.pcPlus2 = pcPlus2;

endmodule

// ==== verilog/memoryStage.sv ====
module memoryStage (
	input logic clk,
	input logic reset,
	input cpuPkg::exMemT exMem,
	output cpuPkg::memWbT memWb
);
	import cpuPkg::*;

	wordT ram [dmemDepth];
	wordT readData;

	// Known contents for loads ahead of any store
	initial begin
		for (int i = 0; i < dmemDepth; i++) begin
			ram[i] = '0;
		end
	end

	// Combinational read at the word index
	assign readData = ram[exMem.aluResult[$clog2(dmemDepth):1]];

	// No stores while in reset
	always_ff @(posedge clk) begin
		if (!reset && exMem.ctrl.memWrite) begin
			ram[exMem.aluResult[$clog2(dmemDepth):1]] <= exMem.storeData;
		end
	end

	always_comb begin
		memWb.regWrite = exMem.ctrl.regWrite;
		memWb.rd = exMem.rd;
		memWb.isHalt = exMem.ctrl.isHalt;
		case (exMem.ctrl.wbSrc)
			srcMem: memWb.wbData = readData;
			srcImm: memWb.wbData = exMem.imm;
			srcPcs: memWb.wbData = exMem.pcPlus2;
			default: memWb.wbData = exMem.aluResult;
		endcase
	end

endmodule

// ==== verilog/pipelineReg.sv ====
module pipelineReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// Flush wins over enable so a held stage can still be squashed
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

	// Disabled stage keeps its payload

endmodule
